/* verilog.f */
+incdir+.
aes_pkg.sv
aes_sbox.sv
aes_round_logic.sv
aes_state_reg.sv
aes_key_sched.sv
aes_round_ctr.sv
aes_ctrl_fsm.sv
aes256_enc_top.sv
aes_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the aes-256 testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module aes_tb -o aes_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/aes_tb_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

/* aes_tb.sv */
module aes_tb;

    import aes_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;      // input skew after the rising edge
    localparam int RESET_CYC  = 10;
    localparam int RUN_CYCLES = 15;     // start edge to done
    localparam int WAIT_LIMIT = 40;     // per block bound on the done wait
    localparam int POKE_EDGE  = 3;      // mid run cycle for the stray start
    localparam int NUM_VEC    = 7;

    // sp 800-38a ecb-aes256 key
    localparam logic [255:0] SP_KEY =
        256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4;

    // one table row
    typedef struct packed {
        logic         poke;     // throw a start at the dut mid run
        logic [255:0] key;
        logic [127:0] pt;
        logic [127:0] ct;
    } vec_t;

    logic       clk;
    logic       resetn;
    logic       start;
    aes_block_t plaintext;
    aes_key_t   key;
    aes_block_t ciphertext;
    logic       busy;
    logic       done;

    vec_t  vectors [NUM_VEC];
    string names [NUM_VEC];
    int    tests_run;
    int    tests_failed;
    int    test_errs;       // failing checks in the current test
    int    total_errs;

    aes256_enc_top dut (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .plaintext  (plaintext),
        .key        (key),
        .ciphertext (ciphertext),
        .busy       (busy),
        .done       (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // bound on the whole run with about 20 cycles per table row
    initial
    begin
        #((RESET_CYC + NUM_VEC * 20 + 50) * CLK_PERIOD);
        $display("timeout: the run did not finish in time and the DUT looks stuck");
        $display("Checks failed");
        $finish;
    end

    // next edge plus skew where outputs have settled
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    task automatic fill_table();
        names[0]   = "fips197_aes256";
        vectors[0] = '{1'b0,
            256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f,
            128'h00112233445566778899aabbccddeeff, 128'h8ea2b7ca516745bfeafc49904b496089};
        names[1]   = "sp800_38a_block1";
        vectors[1] = '{1'b0, SP_KEY,
            128'h6bc1bee22e409f96e93d7e117393172a, 128'hf3eed1bdb5d2a03c064b5a7e3db181f8};
        names[2]   = "sp800_38a_block2";
        vectors[2] = '{1'b0, SP_KEY,
            128'hae2d8a571e03ac9c9eb76fac45af8e51, 128'h591ccb10d410ed26dc5ba74a31362870};
        names[3]   = "sp800_38a_block3";
        vectors[3] = '{1'b0, SP_KEY,
            128'h30c81c46a35ce411e5fbc1191a0a52ef, 128'hb6ed21b99ca6f4f9f153e7b1beafed1d};
        names[4]   = "sp800_38a_block4";
        vectors[4] = '{1'b0, SP_KEY,
            128'hf69f2445df4f9b17ad2b417be66c3710, 128'h23304b7a39f9f3ff067d8d8f9e24ecc7};
        names[5]   = "all_zero";
        vectors[5] = '{1'b0, 256'h0, 128'h0, 128'hdc95c078a2408989ad48a21492842087};
        // same as row 0 but with a stray start while busy
        names[6]   = "start_while_busy";
        vectors[6] = '{1'b1, vectors[0].key, vectors[0].pt, vectors[0].ct};
    endtask

    task automatic finish_test(input string test);
        tests_run++;
        if (test_errs == 0)
        begin
            $display("PASSED %s", test);
        end
        else
        begin
            tests_failed++;
            $display("FAILED %s with %0d failing checks", test, test_errs);
        end
        total_errs += test_errs;
        test_errs   = 0;
    endtask

    // idle outputs straight out of reset
    task automatic check_reset_state();
        repeat (2) next_cycle();
        if (ciphertext !== '0)
        begin
            $display("FAILED reset_state ciphertext: expected %h, actual %h", 128'h0, ciphertext);
            test_errs++;
        end
        if (done !== 1'b0)
        begin
            $display("FAILED reset_state done: expected 0, actual %b", done);
            test_errs++;
        end
        if (busy !== 1'b0)
        begin
            $display("FAILED reset_state busy: expected 0, actual %b", busy);
            test_errs++;
        end
        finish_test("reset_state");
    endtask

    // one block from start strobe to the cycle after done
    task automatic run_block(input int idx);
        vec_t v;
        int   edges;    // edges since the accepted start
        v         = vectors[idx];
        start     = 1'b1;
        key       = v.key;
        plaintext = v.pt;
        next_cycle();               // start edge
        start = 1'b0;
        edges = 0;
        while (done !== 1'b1 && edges < WAIT_LIMIT)
        begin
            if (busy !== 1'b1)
            begin
                $display("FAILED %s busy at cycle %0d: expected 1, actual %b",
                         names[idx], edges, busy);
                test_errs++;
            end
            if (v.poke && edges == POKE_EDGE)
            begin
                start     = 1'b1;   // has to be ignored
                plaintext = {$urandom, $urandom, $urandom, $urandom};
                key       = {$urandom, $urandom, $urandom, $urandom,
                             $urandom, $urandom, $urandom, $urandom};
            end
            else
            begin
                start = 1'b0;
            end
            next_cycle();
            edges++;
        end
        if (done !== 1'b1)
        begin
            $display("%s: done never rose within %0d cycles of start", names[idx], WAIT_LIMIT);
            test_errs++;
        end
        else
        begin
            if (edges != RUN_CYCLES)
            begin
                $display("FAILED %s latency: expected %0d, actual %0d",
                         names[idx], RUN_CYCLES, edges);
                test_errs++;
            end
            if (ciphertext !== v.ct)
            begin
                $display("FAILED %s ciphertext: expected %h, actual %h",
                         names[idx], v.ct, ciphertext);
                test_errs++;
            end
        end
        next_cycle();               // strobe gone and result held
        if (done !== 1'b0)
        begin
            $display("FAILED %s done after strobe: expected 0, actual %b", names[idx], done);
            test_errs++;
        end
        if (busy !== 1'b0)
        begin
            $display("FAILED %s busy after done: expected 0, actual %b", names[idx], busy);
            test_errs++;
        end
        if (ciphertext !== v.ct)
        begin
            $display("FAILED %s held ciphertext: expected %h, actual %h",
                     names[idx], v.ct, ciphertext);
            test_errs++;
        end
        finish_test(names[idx]);
    endtask

    initial
    begin
        void'($urandom(32'h3e87));  // fixed seed for the stray start data
        resetn       = 1'b0;
        start        = 1'b0;
        plaintext    = '0;
        key          = '0;
        tests_run    = 0;
        tests_failed = 0;
        test_errs    = 0;
        total_errs   = 0;
        fill_table();
        repeat (RESET_CYC) @(posedge clk);
        #(DRIVE_DLY);
        resetn = 1'b1;

        check_reset_state();
        // rows back to back with each start one cycle after the previous done
        for (int i = 0; i < NUM_VEC; i++)
            run_block(i);

        $display("tests run: %0d, passed: %0d, failed: %0d, failing checks: %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errs);
        if (tests_failed == 0 && total_errs == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* aes256_enc_top.sv */
module aes256_enc_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  aes_pkg::aes_block_t plaintext,
    input  aes_pkg::aes_key_t   key,
    output aes_pkg::aes_block_t ciphertext,
    output logic                busy,
    output logic                done
);

    import aes_pkg::*;

    aes_ctrl_t  fsm_ctrl;   // load and step only
    aes_ctrl_t  ctrl;       // with last from the counter
    logic       last;
    aes_block_t round_key, white_key;
    aes_block_t init_block;
    aes_block_t mix_out, shf_out;
    aes_block_t state;

    aes_ctrl_fsm u_ctrl_fsm (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .last   (last),
        .ctrl   (fsm_ctrl),
        .busy   (busy),
        .done   (done)
    );

    assign ctrl = '{load: fsm_ctrl.load, step: fsm_ctrl.step, last: last};

    // round index stays internal
    aes_round_ctr u_round_ctr (
        .clk    (clk),
        .resetn (resetn),
        .ctrl   (ctrl),
        .round  (),
        .last   (last)
    );

    aes_key_sched u_key_sched (
        .clk       (clk),
        .resetn    (resetn),
        .ctrl      (ctrl),
        .key       (key),
        .round_key (round_key),
        .white_key (white_key)
    );

    // initial addroundkey
    assign init_block = plaintext ^ white_key;

    aes_round_logic u_round_logic (
        .state     (state),
        .round_key (round_key),
        .mix_out   (mix_out),
        .shf_out   (shf_out)
    );

    aes_state_reg u_state_reg (
        .clk        (clk),
        .resetn     (resetn),
        .ctrl       (ctrl),
        .init_block (init_block),
        .inp_mix    (mix_out),
        .inp_shf    (shf_out),
        .state      (state)
    );

    assign ciphertext = state;

endmodule

/* aes_ctrl_fsm.sv */
module aes_ctrl_fsm (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    input  logic               last,
    output aes_pkg::aes_ctrl_t ctrl,
    output logic               busy,
    output logic               done
);

    typedef enum logic {
        IDLE,
        RUN
    } fsm_state_t;

    fsm_state_t cur_st;
    logic       load_q;     // one cycle after the accepted start
    logic       step_q;     // high for the 14 round cycles

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            cur_st <= IDLE;
            load_q <= 1'b0;
            step_q <= 1'b0;
            done   <= 1'b0;
        end
        else
        begin
            load_q <= 1'b0;
            done   <= 1'b0;
            case (cur_st)
                IDLE:
                begin
                    if (start)
                    begin
                        cur_st <= RUN;
                        load_q <= 1'b1;
                    end
                end
                default:
                begin
                    // start ignored here
                    if (step_q && last)
                    begin
                        step_q <= 1'b0;
                        done   <= 1'b1;
                        cur_st <= IDLE;
                    end
                    else
                    begin
                        step_q <= 1'b1;     // rounds follow the load cycle
                    end
                end
            endcase
        end
    end

    assign busy = (cur_st == RUN);
    // last comes from the counter, merged in the top
    assign ctrl = '{load: load_q, step: step_q, last: 1'b0};

endmodule

/* aes_round_ctr.sv */
`include "aes_cfg.svh"

module aes_round_ctr (
    input  logic               clk,
    input  logic               resetn,
    input  aes_pkg::aes_ctrl_t ctrl,
    output aes_pkg::aes_round_t round,
    output logic               last
);

    import aes_pkg::*;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            round <= '0;
        else if (ctrl.load)
            round <= '0;                // first step is round 0
        else if (ctrl.step)
            round <= round + 1'b1;      // runs to 14 after the final step, harmless
    end

    // mixcolumns skipped here
    assign last = (round == aes_round_t'(`AES_LAST_ROUND));

endmodule

/* aes_key_sched.sv */
module aes_key_sched (
    input  logic                clk,
    input  logic                resetn,
    input  aes_pkg::aes_ctrl_t  ctrl,
    input  aes_pkg::aes_key_t   key,
    output aes_pkg::aes_block_t round_key,
    output aes_pkg::aes_block_t white_key
);

    import aes_pkg::*;

    aes_key_t   win;        // w[j..j+7], w[j] in word 7
    logic       sub_only;   // next update is subword without rotword
    logic [3:0] rc_idx;     // rcon step for the next rotword update
    aes_word_t  sub_in;
    aes_word_t  sub_out;
    aes_word_t  temp;
    aes_word_t  n0, n1, n2, n3;     // w[j+8..j+11]

    // newest word, rotated on the rcon updates
    assign sub_in = sub_only ? win[0] : {win[0][23:0], win[0][31:24]};

    for (genvar i = 0; i < 4; i++)
    begin : g_sub
        aes_sbox u_sbox (
            .in_byte  (sub_in[8*i +: 8]),
            .out_byte (sub_out[8*i +: 8])
        );
    end

    assign temp = sub_only ? sub_out : sub_out ^ {aes_rcon(rc_idx), 24'h000000};

    // chain of four xors
    assign n0 = win[7] ^ temp;
    assign n1 = win[6] ^ n0;
    assign n2 = win[5] ^ n1;
    assign n3 = win[4] ^ n2;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            win      <= '0;
            sub_only <= 1'b0;
            rc_idx   <= 4'd0;
        end
        else if (ctrl.load)
        begin
            win      <= key;
            sub_only <= 1'b0;   // w[8] is a rotword step
            rc_idx   <= 4'd1;
        end
        else if (ctrl.step)
        begin
            // slide by four words
            win      <= {win[3:0], n0, n1, n2, n3};
            sub_only <= ~sub_only;
            if (!sub_only)
                rc_idx <= rc_idx + 4'd1;
        end
    end

    // lower half of the window is the current round key
    assign round_key = win[3:0];
    // w[0..3] straight from the key, needed before the window loads
    assign white_key = key[7:4];

endmodule

/* aes_state_reg.sv */
module aes_state_reg (
    input  logic                clk,
    input  logic                resetn,
    input  aes_pkg::aes_ctrl_t  ctrl,
    input  aes_pkg::aes_block_t init_block,
    input  aes_pkg::aes_block_t inp_mix,
    input  aes_pkg::aes_block_t inp_shf,
    output aes_pkg::aes_block_t state
);

    // round state, also the ciphertext once the run ends
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= '0;
        end
        else if (ctrl.load)
        begin
            state <= init_block;    // plaintext after whitening
        end
        else if (ctrl.step)
        begin
            // round 13 drops mixcolumns
            if (ctrl.last)
                state <= inp_shf;
            else
                state <= inp_mix;
        end
        // otherwise hold, result stays put after done
    end

endmodule

/* aes_round_logic.sv */
module aes_round_logic (
    input  aes_pkg::aes_block_t state,
    input  aes_pkg::aes_block_t round_key,
    output aes_pkg::aes_block_t mix_out,
    output aes_pkg::aes_block_t shf_out
);

    import aes_pkg::*;

    aes_block_t sb;     // after subbytes
    aes_block_t sh;     // after shiftrows
    aes_block_t mc;     // after mixcolumns

    // multiply by x in gf(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aes_word_t mix_col(input aes_word_t col);
        logic [7:0] a0, a1, a2, a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,     // 2 3 1 1
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,     // 1 2 3 1
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,     // 1 1 2 3
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};    // 3 1 1 2
    endfunction

    // subbytes, one sbox per byte
    for (genvar k = 0; k < 16; k++)
    begin : g_sub
        aes_sbox u_sbox (
            .in_byte  (state[k]),
            .out_byte (sb[k])
        );
    end

    // row r rotates left by r, fips byte r+4c lives at index 15-r-4c
    always_comb
    begin
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
                sh[15 - r - 4*c] = sb[15 - r - 4*((c + r) % 4)];
        end
    end

    // column c is bytes 15-4c down to 12-4c
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            {mc[15 - 4*c], mc[14 - 4*c], mc[13 - 4*c], mc[12 - 4*c]} =
                mix_col({sh[15 - 4*c], sh[14 - 4*c], sh[13 - 4*c], sh[12 - 4*c]});
        end
    end

    // both candidates, register picks one
    assign mix_out = mc ^ round_key;
    assign shf_out = sh ^ round_key;    // final round form

endmodule

/* aes_sbox.sv */
module aes_sbox (
    input  logic [7:0] in_byte,
    output logic [7:0] out_byte
);

    logic [127:0] row;      // one table row, column 0 in the top byte
    logic [3:0]   col_sel;  // byte position counted from the bottom

    // upper nibble picks the row
    always_comb
    begin
        case (in_byte[7:4])
            4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
            4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
            4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
            4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
            4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
            4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
            4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
            4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
            4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
            4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
            4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
            4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
            4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
            4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
            4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
            default: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
        endcase
    end

    // 15 - lo, since column 0 sits at the msb end
    assign col_sel  = ~in_byte[3:0];
    assign out_byte = row[{col_sel, 3'b000} +: 8];

endmodule

/* aes_pkg.sv */
`include "aes_cfg.svh"

package aes_pkg;

    // 16 bytes, byte 15 is fips byte 0
    typedef logic [15:0][7:0] aes_block_t;

    // one column, top byte is row 0
    typedef logic [31:0] aes_word_t;

    // eight words, word 7 is w[0]
    typedef aes_word_t [7:0] aes_key_t;

    typedef logic [`AES_ROUND_W-1:0] aes_round_t;

    // round sequencing strobes
    typedef struct packed {
        logic load;     // take plaintext and key
        logic step;     // advance one round
        logic last;     // current round skips mixcolumns
    } aes_ctrl_t;

    // round constant for expansion step idx (1 based)
    function automatic logic [7:0] aes_rcon(input logic [3:0] idx);
        case (idx)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

endpackage

/* aes_cfg.svh */
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// aes-256 round schedule
`define AES_NUM_ROUNDS 14                       // full rounds after whitening
`define AES_LAST_ROUND (`AES_NUM_ROUNDS - 1)    // index 13, no mixcolumns

// round index register
`define AES_ROUND_W 4

`endif
